/* tcdm_bank.sv */
// ##########################################################################
// single-port SRAM model for one channel, 2**ADDR_W words
// writes land at the grant edge under the byte enables
// read data is registered and held until the next read
// ##########################################################################

`timescale 1ns/100ps

module tcdm_bank (
  input  logic                          clk_i,
  input  tcdm_pkg::tcdm_req_t           bank_req_i,  // already arbitrated
  output logic [tcdm_pkg::DATA_W-1:0]   rdata_o
);

  localparam int NB_WORDS = 2 ** tcdm_pkg::ADDR_W;

  logic [tcdm_pkg::DATA_W-1:0] mem_q [NB_WORDS];  // storage, starts unknown
  logic [tcdm_pkg::DATA_W-1:0] rdata_q;           // output register

  // write port, one byte lane per enable bit
  always_ff @(posedge clk_i)
  begin
    if (bank_req_i.req && !bank_req_i.wen)
    begin
      for (int b = 0; b < tcdm_pkg::BE_W; b++)
      begin
        if (bank_req_i.be[b])
          mem_q[bank_req_i.add][b*8 +: 8] <= bank_req_i.data[b*8 +: 8];
      end
    end
  end

  // read port
  // the data register only loads on a granted read, so the value stays
  // visible through any number of idle or write cycles that follow
  always_ff @(posedge clk_i)
  begin
    if (bank_req_i.req && bank_req_i.wen)
      rdata_q <= mem_q[bank_req_i.add];  // one cycle read latency
  end

  assign rdata_o = rdata_q;

endmodule

/* tcdm_pkg.sv */
// ##########################################################################
// shared sizes and types of the two-channel TCDM interconnect
// request, response and control structs travel as packed structs
// every design file takes what it needs by tcdm_pkg:: scoped names
// ##########################################################################

package tcdm_pkg;

  // one bank per channel, no address interleaving
  localparam int NB_CHAN = 2;

  localparam int ADDR_W  = 8;          // word address inside one bank, 256 words
  localparam int DATA_W  = 32;
  localparam int BE_W    = DATA_W / 8; // one enable per byte lane
  localparam int STALL_W = 8;          // starvation limit and counter width

  // request from one initiator side on one channel, 46 bits
  typedef struct packed {
    logic              req;   // held until gnt
    logic [ADDR_W-1:0] add;   // word address
    logic              wen;   // 1 read, 0 write
    logic [BE_W-1:0]   be;    // byte enables, writes only
    logic [DATA_W-1:0] data;  // write data
  } tcdm_req_t;

  // read response toward one side, 33 bits
  typedef struct packed {
    logic              r_valid;  // single-cycle pulse
    logic [DATA_W-1:0] r_data;
  } tcdm_resp_t;

  // software control word, quasi-static
  typedef struct packed {
    logic               swap_prio;  // 1 favors the low side
    logic [STALL_W-1:0] max_stall;  // 0 turns the starvation override off
  } tcdm_ctrl_t;

  // arbiter to router tag, one per channel
  typedef struct packed {
    logic read_gnt;  // a read was granted this cycle
    logic to_high;   // grant went to the high side
  } tcdm_side_t;

endpackage

/* tcdm_prio_arbiter.sv */
// ##########################################################################
// fixed-priority side select at the bank boundary, one decision per channel
// swap_prio flips the favored side, max_stall lets the other side through
// grants are combinational from the requests, the banks never stall
// ##########################################################################

`timescale 1ns/100ps

module tcdm_prio_arbiter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,     // restarts the stall count
  input  tcdm_pkg::tcdm_ctrl_t          ctrl_i,
  input  tcdm_pkg::tcdm_req_t           high_req_i [tcdm_pkg::NB_CHAN],
  input  tcdm_pkg::tcdm_req_t           low_req_i  [tcdm_pkg::NB_CHAN],
  output logic [tcdm_pkg::NB_CHAN-1:0]  high_gnt_o,
  output logic [tcdm_pkg::NB_CHAN-1:0]  low_gnt_o,
  output tcdm_pkg::tcdm_req_t           bank_req_o [tcdm_pkg::NB_CHAN],
  output tcdm_pkg::tcdm_side_t          side_o     [tcdm_pkg::NB_CHAN]
);

  logic [tcdm_pkg::NB_CHAN-1:0] fav_req;    // requests of the favored side
  logic [tcdm_pkg::NB_CHAN-1:0] unfav_req;  // requests of the other side
  logic [tcdm_pkg::NB_CHAN-1:0] fav_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] unfav_gnt;
  logic                         contend;    // both sides want some channel
  logic                         override;   // unfavored side owns every channel
  logic [tcdm_pkg::STALL_W-1:0] stall_cnt_q;

  // map high/low onto favored/unfavored
  for (genvar c = 0; c < tcdm_pkg::NB_CHAN; c++)
  begin : g_side_map
    always_comb
    begin
      if (ctrl_i.swap_prio)
      begin
        fav_req[c]   = low_req_i[c].req;   // accelerator first
        unfav_req[c] = high_req_i[c].req;
      end
      else
      begin
        fav_req[c]   = high_req_i[c].req;  // cores first, default
        unfav_req[c] = low_req_i[c].req;
      end
    end
  end

  // contention is seen per channel and then reduced over all channels
  assign contend = |(fav_req & unfav_req);

  // counter at or past the limit lets the unfavored side in this cycle
  assign override = (ctrl_i.max_stall != '0) && (stall_cnt_q >= ctrl_i.max_stall);

  // consecutive contending cycles, saturates instead of wrapping
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_cnt_q <= '0;
    else if (clear_i || !contend)
      stall_cnt_q <= '0;                    // any quiet cycle restarts it
    else if (stall_cnt_q != '1)
      stall_cnt_q <= stall_cnt_q + 1'b1;
  end

  for (genvar c = 0; c < tcdm_pkg::NB_CHAN; c++)
  begin : g_grant
    // favored wins unless overridden, otherwise the channel belongs to the other side
    assign fav_gnt[c]   = fav_req[c] & ~override;
    assign unfav_gnt[c] = unfav_req[c] & ~fav_gnt[c];

    // back from favored/unfavored to high/low
    assign high_gnt_o[c] = ctrl_i.swap_prio ? unfav_gnt[c] : fav_gnt[c];
    assign low_gnt_o[c]  = ctrl_i.swap_prio ? fav_gnt[c]   : unfav_gnt[c];

    // bank port mux, req follows the grant so an idle cycle is a no-op
    always_comb
    begin
      if (high_gnt_o[c])
        bank_req_o[c] = high_req_i[c];
      else
        bank_req_o[c] = low_req_i[c];  // also the idle default
      bank_req_o[c].req = high_gnt_o[c] | low_gnt_o[c];

      // tag for the response router
      side_o[c].read_gnt = bank_req_o[c].req & bank_req_o[c].wen;
      side_o[c].to_high  = high_gnt_o[c];
    end
  end

endmodule

/* tcdm_resp_router.sv */
// ##########################################################################
// response side of the interconnect, one lane per channel
// delays the arbiter's side tag by one cycle to line up with bank data
// and raises r_valid only toward the side that owned the read
// ##########################################################################

`timescale 1ns/100ps

module tcdm_resp_router (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,  // drops reads still in the bank
  input  tcdm_pkg::tcdm_side_t          side_i   [tcdm_pkg::NB_CHAN],
  input  logic [tcdm_pkg::DATA_W-1:0]   rdata_i  [tcdm_pkg::NB_CHAN],
  output tcdm_pkg::tcdm_resp_t          high_resp_o [tcdm_pkg::NB_CHAN],
  output tcdm_pkg::tcdm_resp_t          low_resp_o  [tcdm_pkg::NB_CHAN]
);

  tcdm_pkg::tcdm_side_t side_q [tcdm_pkg::NB_CHAN];  // tag of the read now in the bank

  for (genvar c = 0; c < tcdm_pkg::NB_CHAN; c++)
  begin : g_lane

    // tag pipeline stage, same depth as the bank read register
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        side_q[c] <= '0;
      else if (clear_i)
        side_q[c] <= '0;          // no response after a clear
      else
        side_q[c] <= side_i[c];   // also clears itself on non-read cycles
    end

    // valid is built here, the arbiter passes none
    always_comb
    begin
      high_resp_o[c].r_valid = side_q[c].read_gnt & side_q[c].to_high;
      low_resp_o[c].r_valid  = side_q[c].read_gnt & ~side_q[c].to_high;

      // data fans out to both sides, valid tells who owns it
      high_resp_o[c].r_data  = rdata_i[c];
      low_resp_o[c].r_data   = rdata_i[c];
    end

  end

endmodule

/* tcdm_subsystem.sv */
// ##########################################################################
// top of the two-channel TCDM interconnect
// arbitration, one SRAM bank per channel, then response routing
// gnt is combinational from req, r_valid follows a read grant by one cycle
// ##########################################################################

`timescale 1ns/100ps

module tcdm_subsystem (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  tcdm_pkg::tcdm_ctrl_t          ctrl_i,
  input  tcdm_pkg::tcdm_req_t           high_req_i  [tcdm_pkg::NB_CHAN],  // cores
  input  tcdm_pkg::tcdm_req_t           low_req_i   [tcdm_pkg::NB_CHAN],  // accelerator
  output logic [tcdm_pkg::NB_CHAN-1:0]  high_gnt_o,
  output logic [tcdm_pkg::NB_CHAN-1:0]  low_gnt_o,
  output tcdm_pkg::tcdm_resp_t          high_resp_o [tcdm_pkg::NB_CHAN],
  output tcdm_pkg::tcdm_resp_t          low_resp_o  [tcdm_pkg::NB_CHAN]
);

  tcdm_pkg::tcdm_req_t         bank_req  [tcdm_pkg::NB_CHAN];  // winning request per bank
  tcdm_pkg::tcdm_side_t        side_info [tcdm_pkg::NB_CHAN];  // read grant owner
  logic [tcdm_pkg::DATA_W-1:0] bank_rdata [tcdm_pkg::NB_CHAN];

  // stage 1, side selection
  tcdm_prio_arbiter u_arb (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .ctrl_i     (ctrl_i),
    .high_req_i (high_req_i),
    .low_req_i  (low_req_i),
    .high_gnt_o (high_gnt_o),
    .low_gnt_o  (low_gnt_o),
    .bank_req_o (bank_req),
    .side_o     (side_info)
  );

  // stage 2, one bank per channel
  for (genvar c = 0; c < tcdm_pkg::NB_CHAN; c++)
  begin : g_bank
    tcdm_bank u_bank (
      .clk_i      (clk_i),
      .bank_req_i (bank_req[c]),
      .rdata_o    (bank_rdata[c])
    );
  end

  // stage 3, responses back to the owning side
  tcdm_resp_router u_router (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .side_i      (side_info),
    .rdata_i     (bank_rdata),
    .high_resp_o (high_resp_o),
    .low_resp_o  (low_resp_o)
  );

endmodule

/* tcdm_tb.sv */
// ##########################################################################
// testbench for the two-channel TCDM interconnect
// runs random and directed request phases, inputs change on the falling edge
// the bound checker u_sb_assert does the checking, this module stops the run
// ##########################################################################

`timescale 1ns/100ps

module tcdm_tb;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         clear;
  tcdm_pkg::tcdm_ctrl_t         ctrl;
  tcdm_pkg::tcdm_req_t          high_req  [tcdm_pkg::NB_CHAN];  // cores
  tcdm_pkg::tcdm_req_t          low_req   [tcdm_pkg::NB_CHAN];  // accelerator
  logic [tcdm_pkg::NB_CHAN-1:0] high_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] low_gnt;
  tcdm_pkg::tcdm_resp_t         high_resp [tcdm_pkg::NB_CHAN];
  tcdm_pkg::tcdm_resp_t         low_resp  [tcdm_pkg::NB_CHAN];
  logic [tcdm_pkg::NB_CHAN-1:0] high_gnt_q;  // grants taken at the last rising edge
  logic [tcdm_pkg::NB_CHAN-1:0] low_gnt_q;

  tcdm_subsystem u_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear),
    .ctrl_i      (ctrl),
    .high_req_i  (high_req),
    .low_req_i   (low_req),
    .high_gnt_o  (high_gnt),
    .low_gnt_o   (low_gnt),
    .high_resp_o (high_resp),
    .low_resp_o  (low_resp)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  always @(posedge clk_i)
  begin
    high_gnt_q <= high_gnt;
    low_gnt_q  <= low_gnt;
  end

  // first failed assertion ends the run
  always @(negedge clk_i)
  begin
    if (u_dut.u_sb_assert.fail_cnt != 0)
    begin
      $display("Result: FAILED");
      $fatal(1, "the checker reported a failed assertion");
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "run stopped on a timeout");
  endtask

  // addresses 0 to 15 only, all of them preloaded
  function automatic tcdm_pkg::tcdm_req_t rand_req();
    tcdm_pkg::tcdm_req_t r;
    logic [31:0]         rnd;
    rnd        = $urandom;
    r          = '0;
    r.req      = 1'b1;
    r.wen      = rnd[0];
    r.be       = rnd[4:1];
    r.add[3:0] = rnd[8:5];
    r.data     = $urandom;
    return r;
  endfunction

  task automatic retire_granted();
    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
    begin
      if (high_gnt_q[c])
        high_req[c].req = 1'b0;  // done at the last edge
      if (low_gnt_q[c])
        low_req[c].req = 1'b0;
    end
  endtask

  function automatic logic any_pending();
    logic p;
    p = 1'b0;
    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
      p = p | high_req[c].req | low_req[c].req;
    return p;
  endfunction

  task automatic drop_all();
    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
    begin
      high_req[c] = '0;
      low_req[c]  = '0;
    end
  endtask

  task automatic preload_word(input int c, input logic [tcdm_pkg::ADDR_W-1:0] add,
                              input logic [tcdm_pkg::DATA_W-1:0] data);
    int n;
    high_req[c] = '{req: 1'b1, add: add, wen: 1'b0, be: '1, data: data};
    n = 0;
    @(negedge clk_i);
    while (!high_gnt_q[c])
    begin
      if (n >= 10)
        stop_on_timeout("a preload write grant");
      n++;
      @(negedge clk_i);
    end
    high_req[c].req = 1'b0;
  endtask

  // requests held until granted, then a new one with probability one half
  task automatic random_phase(input int cycles);
    int n;
    repeat (cycles)
    begin
      @(negedge clk_i);
      retire_granted();
      for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
      begin
        if (!high_req[c].req && $urandom_range(1) == 1)
          high_req[c] = rand_req();
        if (!low_req[c].req && $urandom_range(1) == 1)
          low_req[c] = rand_req();
      end
    end
    n = 0;
    while (any_pending())  // drain without new requests
    begin
      if (n >= 50)
        stop_on_timeout("the random requests to drain");
      n++;
      @(negedge clk_i);
      retire_granted();
    end
  endtask

  // low side of channel 0 must get in within limit cycles
  task automatic wait_low_grant(input int limit);
    int n;
    n = 1;  // contending cycles seen so far
    @(negedge clk_i);
    while (!low_gnt_q[0])
    begin
      if (n >= limit)
        stop_on_timeout("the starvation override grant");
      n++;
      @(negedge clk_i);
    end
  endtask

  initial
  begin
    void'($urandom(41826));
    rst_ni = 1'b1;
    clear  = 1'b0;
    ctrl   = '0;
    drop_all();
    #1 rst_ni = 1'b0;           // async, before the first edge
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
      for (int a = 0; a < 16; a++)
        preload_word(c, a, $urandom);

    // priority with and without swap, then with the override on
    random_phase(200);
    ctrl = '{swap_prio: 1'b1, max_stall: 8'd0};
    random_phase(200);
    ctrl = '{swap_prio: 1'b0, max_stall: 8'd3};
    random_phase(200);

    // both sides read channel 0 on every cycle
    high_req[0] = '{req: 1'b1, add: 8'h01, wen: 1'b1, be: '0, data: '0};
    low_req[0]  = '{req: 1'b1, add: 8'h02, wen: 1'b1, be: '0, data: '0};
    wait_low_grant(int'(ctrl.max_stall) + 1);
    clear = 1'b1;  // count restarts under the same contention
    @(negedge clk_i);
    clear = 1'b0;
    wait_low_grant(int'(ctrl.max_stall) + 1);
    drop_all();

    // reset with reads in flight on channel 1
    @(negedge clk_i);
    high_req[1] = '{req: 1'b1, add: 8'h03, wen: 1'b1, be: '0, data: '0};
    low_req[1]  = '{req: 1'b1, add: 8'h04, wen: 1'b1, be: '0, data: '0};
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    drop_all();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    ctrl = '{swap_prio: 1'b1, max_stall: 8'd2};
    random_phase(150);
    repeat (2) @(negedge clk_i);

    if (u_dut.u_sb_assert.fail_cnt != 0)
    begin
      $display("Result: FAILED");
      $fatal(1, "the checker reported failed assertions");
    end
    else
    begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

/* tcdm_tb_assert.sv */
// ##########################################################################
// checker bound into tcdm_subsystem, keeps a shadow memory per bank and a
// model of the stall counter, every rule is a concurrent assertion
// fail_cnt counts failed assertions so the testbench can stop the run
// ##########################################################################

`timescale 1ns/100ps

module tcdm_sb_assert (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         clear,
  input tcdm_pkg::tcdm_ctrl_t         ctrl,
  input tcdm_pkg::tcdm_req_t          high_req  [tcdm_pkg::NB_CHAN],
  input tcdm_pkg::tcdm_req_t          low_req   [tcdm_pkg::NB_CHAN],
  input logic [tcdm_pkg::NB_CHAN-1:0] high_gnt,
  input logic [tcdm_pkg::NB_CHAN-1:0] low_gnt,
  input tcdm_pkg::tcdm_resp_t         high_resp [tcdm_pkg::NB_CHAN],
  input tcdm_pkg::tcdm_resp_t         low_resp  [tcdm_pkg::NB_CHAN]
);

  logic [tcdm_pkg::DATA_W-1:0]  shadow [tcdm_pkg::NB_CHAN][2**tcdm_pkg::ADDR_W];
  tcdm_pkg::tcdm_req_t          win     [tcdm_pkg::NB_CHAN];  // request that got the bank
  logic [tcdm_pkg::NB_CHAN-1:0] win_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] fav_req;
  logic [tcdm_pkg::NB_CHAN-1:0] unfav_req;
  logic [tcdm_pkg::NB_CHAN-1:0] fav_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] unfav_gnt;
  logic [tcdm_pkg::NB_CHAN-1:0] high_rd_q;  // high owned a read last cycle
  logic [tcdm_pkg::NB_CHAN-1:0] low_rd_q;
  logic [tcdm_pkg::DATA_W-1:0]  exp_q   [tcdm_pkg::NB_CHAN];  // shadow word of that read
  logic [tcdm_pkg::DATA_W-1:0]  rd_data [tcdm_pkg::NB_CHAN];  // data at the owning side
  logic                         override;
  int                           stall_q;                      // contending cycles in a row
  int                           fail_cnt = 0;

  always_comb
  begin
    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
    begin
      fav_req[c]   = ctrl.swap_prio ? low_req[c].req  : high_req[c].req;
      unfav_req[c] = ctrl.swap_prio ? high_req[c].req : low_req[c].req;
      fav_gnt[c]   = ctrl.swap_prio ? low_gnt[c]      : high_gnt[c];
      unfav_gnt[c] = ctrl.swap_prio ? high_gnt[c]     : low_gnt[c];
      win[c]       = high_gnt[c] ? high_req[c] : low_req[c];
      win_gnt[c]   = high_gnt[c] | low_gnt[c];
      rd_data[c]   = high_rd_q[c] ? high_resp[c].r_data : low_resp[c].r_data;
    end
  end

  assign override = (ctrl.max_stall != '0) && (stall_q >= int'(ctrl.max_stall));

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_q <= 0;
    else if (clear || !(|(fav_req & unfav_req)))
      stall_q <= 0;  // quiet cycle or clear restarts the count
    else
      stall_q <= stall_q + 1;
  end

  // expected response owner, one cycle behind the grant
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      high_rd_q <= '0;
      low_rd_q  <= '0;
    end
    else
    begin
      for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
      begin
        high_rd_q[c] <= high_gnt[c] & high_req[c].wen & ~clear;
        low_rd_q[c]  <= low_gnt[c] & low_req[c].wen & ~clear;
      end
    end
  end

  // shadow memory, byte lanes under be
  always_ff @(posedge clk_i)
  begin
    for (int c = 0; c < tcdm_pkg::NB_CHAN; c++)
    begin
      if (win_gnt[c] && !win[c].wen)
      begin
        for (int b = 0; b < tcdm_pkg::BE_W; b++)
        begin
          if (win[c].be[b])
            shadow[c][win[c].add][b*8 +: 8] <= win[c].data[b*8 +: 8];
        end
      end
      if (win_gnt[c] && win[c].wen)
        exp_q[c] <= shadow[c][win[c].add];  // word before this edge
    end
  end

  for (genvar c = 0; c < tcdm_pkg::NB_CHAN; c++)
  begin : g_chk
    a_one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(high_gnt[c] && low_gnt[c]))
    else begin $error("two grants at once on channel %0d", c); fail_cnt++; end

    a_high_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
      high_gnt[c] |-> high_req[c].req)
    else begin $error("high grant without request on channel %0d", c); fail_cnt++; end

    a_low_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
      low_gnt[c] |-> low_req[c].req)
    else begin $error("low grant without request on channel %0d", c); fail_cnt++; end

    a_fav_wins: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (fav_req[c] && !override) |-> fav_gnt[c])
    else begin $error("favored side lost channel %0d", c); fail_cnt++; end

    // starvation override or an idle favored side hands the channel over
    a_unfav_owns: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!fav_req[c] || override) |-> (unfav_gnt[c] == unfav_req[c]) && !fav_gnt[c])
    else begin $error("unfavored side not served on channel %0d", c); fail_cnt++; end

    a_high_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      high_resp[c].r_valid == high_rd_q[c])
    else begin $error("wrong high r_valid on channel %0d", c); fail_cnt++; end

    a_low_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      low_resp[c].r_valid == low_rd_q[c])
    else begin $error("wrong low r_valid on channel %0d", c); fail_cnt++; end

    a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (high_rd_q[c] || low_rd_q[c]) |-> (rd_data[c] === exp_q[c]))
    else
    begin
      $error("error data_integrity ch%0d: expected %h actual %h", c,
             $sampled(exp_q[c]), $sampled(rd_data[c]));
      fail_cnt++;
    end

    a_reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |-> !high_resp[c].r_valid && !low_resp[c].r_valid)
    else begin $error("r_valid during reset on channel %0d", c); fail_cnt++; end
  end

endmodule

bind tcdm_subsystem tcdm_sb_assert u_sb_assert (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .clear     (clear_i),
  .ctrl      (ctrl_i),
  .high_req  (high_req_i),
  .low_req   (low_req_i),
  .high_gnt  (high_gnt_o),
  .low_gnt   (low_gnt_o),
  .high_resp (high_resp_o),
  .low_resp  (low_resp_o)
);

/* vlog.f */
tcdm_pkg.sv
tcdm_prio_arbiter.sv
tcdm_bank.sv
tcdm_resp_router.sv
tcdm_subsystem.sv
tcdm_tb_assert.sv
tcdm_tb.sv
